// ==== Makefile ====
# Verilator lint, simulation and clean for the five-stage core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module cpu_top -f list.f
	verilator --lint-only --timing --top-module tb_cpu -f list.f

sim:
	verilator --binary --timing --top-module tb_cpu -Mdir obj_dir -f list.f
	-./obj_dir/Vtb_cpu > sim.log 2>&1
	cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/cpu_decode.sv ====
/*
 Decode stage with register read addresses and load-use detection
 Only a load still sitting in decode/execute can stall, and only for one cycle
 Stall and redirect both turn the decode/execute slot into a bubble
*/
`timescale 1ns/1ns

module cpu_decode (
   input  logic              clk,
   input  logic              clr,
   input  cpu_pkg::word_t    fd_pc,
   input  cpu_pkg::word_t    fd_instr,
   input  logic              redirect,
   output cpu_pkg::reg_idx_t rd_addr_a,
   output cpu_pkg::reg_idx_t rd_addr_b,
   input  cpu_pkg::word_t    rd_data_a,
   input  cpu_pkg::word_t    rd_data_b,
   output logic              stall,
   output cpu_pkg::word_t    dx_pc,
   output cpu_pkg::word_t    dx_instr,
   output cpu_pkg::word_t    dx_a,
   output cpu_pkg::word_t    dx_b
);
   import cpu_pkg::*;

   reg_idx_t load_rd;
   logic     dx_is_load;
   logic     hit_a;
   logic     hit_b;

   assign rd_addr_a = src_a(fd_instr);
   assign rd_addr_b = src_b(fd_instr);

   // Load data is not ready until writeback
   assign load_rd    = rd_of(dx_instr);
   assign dx_is_load = (op_of(dx_instr) == op_lw) && (load_rd != '0);
   assign hit_a      = reads_a(fd_instr) && (rd_addr_a == load_rd);
   assign hit_b      = reads_b(fd_instr) && (rd_addr_b == load_rd);
   assign stall      = dx_is_load && (hit_a || hit_b);

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         dx_instr <= nop_word;
      end else if (stall || redirect) begin
         dx_instr <= nop_word;      // Bubble
      end else begin
         dx_instr <= fd_instr;
      end
   end

   always_ff @(posedge clk) begin
      dx_pc <= fd_pc;
      dx_a  <= rd_data_a;
      dx_b  <= rd_data_b;
   end

endmodule

// ==== hw/cpu_execute.sv ====
/*
 Execute stage: operand forwarding, ALU, branch and jump resolution
 Forwarding priority is execute/memory, then writeback, then the register read
 Loads never forward from execute/memory, decode stalls instead
 The execute/memory register also drives the data memory port directly
*/
`timescale 1ns/1ns

module cpu_execute (
   input  logic              clk,
   input  logic              clr,
   input  cpu_pkg::word_t    dx_pc,
   input  cpu_pkg::word_t    dx_instr,
   input  cpu_pkg::word_t    dx_a,
   input  cpu_pkg::word_t    dx_b,
   input  logic              wb_en,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  cpu_pkg::word_t    wb_data,
   output logic              redirect,
   output cpu_pkg::word_t    redirect_pc,
   output cpu_pkg::word_t    xm_instr,
   output cpu_pkg::word_t    xm_result,
   output cpu_pkg::word_t    dmem_addr,
   output cpu_pkg::word_t    dmem_wdata,
   output logic              dmem_we
);
   import cpu_pkg::*;

   opcode_e  op;
   word_t    imm;
   word_t    op_a;
   word_t    op_b;
   word_t    result;
   logic     xm_fwd;
   reg_idx_t xm_rd;

   assign op     = op_of(dx_instr);
   assign imm    = imm_of(dx_instr);
   assign xm_rd  = rd_of(xm_instr);
   assign xm_fwd = writes_rd(xm_instr) && (op_of(xm_instr) != op_lw);

   function automatic word_t fwd(reg_idx_t src, word_t read_val);
      if (xm_fwd && (xm_rd == src)) begin
         return xm_result;
      end
      if (wb_en && (wb_reg == src)) begin
         return wb_data;
      end
      return read_val;
   endfunction

   always_comb begin
      op_a = fwd(src_a(dx_instr), dx_a);
      op_b = fwd(src_b(dx_instr), dx_b);
   end

   always_comb begin
      result = op_a + imm;          // addi and load/store address
      if (op == op_alu) begin
         case (fn_of(dx_instr))
            fn_add:  result = op_a + op_b;
            fn_sub:  result = op_a - op_b;
            fn_and:  result = op_a & op_b;
            fn_or:   result = op_a | op_b;
            fn_sll:  result = op_a << shamt_of(dx_instr);
            fn_sra:  result = word_t'($signed(op_a) >>> shamt_of(dx_instr));
            default: result = '0;
         endcase
      end
   end

   // bne compares rd against rs, target is relative to the next PC
   assign redirect    = ((op == op_bne) && (op_a != op_b)) || (op == op_j);
   assign redirect_pc = (op == op_j) ? target_of(dx_instr) : dx_pc + word_t'(1) + imm;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         xm_instr <= nop_word;
      end else begin
         xm_instr <= dx_instr;
      end
   end

   always_ff @(posedge clk) begin
      xm_result  <= result;
      dmem_wdata <= op_b;           // Store data, rd on port b
   end

   assign dmem_addr = xm_result;
   assign dmem_we   = (op_of(xm_instr) == op_sw);

endmodule

// ==== hw/cpu_fetch.sv ====
/*
 Program counter and fetch/decode register
 A redirect wins over a stall and squashes the instruction being fetched
*/
`timescale 1ns/1ns

module cpu_fetch #(
   parameter cpu_pkg::word_t reset_pc = '0
) (
   input  logic           clk,
   input  logic           clr,
   input  logic           stall,
   input  logic           redirect,
   input  cpu_pkg::word_t redirect_pc,
   output cpu_pkg::word_t imem_addr,
   input  cpu_pkg::word_t imem_data,
   output cpu_pkg::word_t fd_pc,
   output cpu_pkg::word_t fd_instr
);
   import cpu_pkg::*;

   word_t pc;

   assign imem_addr = pc;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         pc       <= reset_pc;
         fd_instr <= nop_word;
      end else if (redirect) begin
         pc       <= redirect_pc;
         fd_instr <= nop_word;      // Wrong-path fetch
      end else if (!stall) begin
         pc       <= pc + word_t'(1);
         fd_instr <= imem_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         fd_pc <= pc;               // Address of the fetched word
      end
   end

endmodule

// ==== hw/cpu_pkg.sv ====
/*
 Shared widths, instruction fields and decode helpers for the five-stage core
 Program and data addresses are word indices, so the PC steps by one
 Immediates are 17 bits and jump targets 27 bits, both sign-extended
*/
package cpu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int op_w       = 5;

   typedef logic [xlen-1:0]       word_t;
   typedef logic [reg_addr_w-1:0] reg_idx_t;

   // Field positions, lsb of each field
   localparam int op_lsb    = 27;
   localparam int rd_lsb    = 22;
   localparam int rs_lsb    = 17;
   localparam int rt_lsb    = 12;
   localparam int shamt_lsb = 7;
   localparam int fn_lsb    = 2;
   localparam int imm_w     = 17;
   localparam int target_w  = 27;

   typedef enum logic [op_w-1:0] {
      op_alu  = 5'd0,
      op_j    = 5'd1,
      op_bne  = 5'd2,
      op_addi = 5'd5,
      op_sw   = 5'd7,
      op_lw   = 5'd8
   } opcode_e;

   typedef enum logic [op_w-1:0] {
      fn_add = 5'd0,
      fn_sub = 5'd1,
      fn_and = 5'd2,
      fn_or  = 5'd3,
      fn_sll = 5'd4,
      fn_sra = 5'd5
   } alu_fn_e;

   localparam word_t nop_word = '0;  // add r0, r0, r0

   function automatic opcode_e op_of(word_t instr);
      return opcode_e'(instr[op_lsb +: op_w]);
   endfunction

   function automatic alu_fn_e fn_of(word_t instr);
      return alu_fn_e'(instr[fn_lsb +: op_w]);
   endfunction

   function automatic reg_idx_t rd_of(word_t instr);
      return instr[rd_lsb +: reg_addr_w];
   endfunction

   function automatic reg_idx_t rs_of(word_t instr);
      return instr[rs_lsb +: reg_addr_w];
   endfunction

   function automatic reg_idx_t rt_of(word_t instr);
      return instr[rt_lsb +: reg_addr_w];
   endfunction

   function automatic logic [4:0] shamt_of(word_t instr);
      return instr[shamt_lsb +: 5];
   endfunction

   function automatic word_t imm_of(word_t instr);
      return {{(xlen-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
   endfunction

   function automatic word_t target_of(word_t instr);
      return {{(xlen-target_w){instr[target_w-1]}}, instr[target_w-1:0]};
   endfunction

   // Port a carries rd for bne, rs otherwise
   function automatic reg_idx_t src_a(word_t instr);
      return (op_of(instr) == op_bne) ? rd_of(instr) : rs_of(instr);
   endfunction

   // Port b carries rs for bne, the store data register for sw
   function automatic reg_idx_t src_b(word_t instr);
      if (op_of(instr) == op_bne) begin
         return rs_of(instr);
      end
      return (op_of(instr) == op_sw) ? rd_of(instr) : rt_of(instr);
   endfunction

   function automatic logic reads_a(word_t instr);
      return op_of(instr) != op_j;
   endfunction

   function automatic logic reads_b(word_t instr);
      return op_of(instr) inside {op_alu, op_sw, op_bne};
   endfunction

   // r0 targets never count as a write
   function automatic logic writes_rd(word_t instr);
      return (op_of(instr) inside {op_alu, op_addi, op_lw}) && (rd_of(instr) != '0);
   endfunction

endpackage

// ==== hw/cpu_regfile.sv ====
/*
 32 x 32 register file, two read ports and one write port
 r0 always reads zero, and a read of the register being written sees the new word
*/
`timescale 1ns/1ns

module cpu_regfile (
   input  logic              clk,
   input  logic              clr,
   input  cpu_pkg::reg_idx_t rd_addr_a,
   input  cpu_pkg::reg_idx_t rd_addr_b,
   output cpu_pkg::word_t    rd_data_a,
   output cpu_pkg::word_t    rd_data_b,
   input  logic              wb_en,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   localparam int nregs = 2**reg_addr_w;

   word_t regs [nregs];

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         for (int i = 0; i < nregs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && (wb_reg != '0)) begin
         regs[wb_reg] <= wb_data;
      end
   end

   assign rd_data_a = (rd_addr_a == '0) ? '0 :
                      (wb_en && (wb_reg == rd_addr_a)) ? wb_data : regs[rd_addr_a];
   assign rd_data_b = (rd_addr_b == '0) ? '0 :
                      (wb_en && (wb_reg == rd_addr_b)) ? wb_data : regs[rd_addr_b];

endmodule

// ==== hw/cpu_top.sv ====
/*
 Five-stage in-order core: fetch, decode, execute, memory, writeback
 Instruction memory is read combinationally in the fetch cycle
 Data memory writes on the edge with dmem_we high, reads return one cycle later
 The wb_* outputs mirror the register file write port, one pulse per retirement
*/
`timescale 1ns/1ns

module cpu_top #(
   parameter cpu_pkg::word_t reset_pc = '0
) (
   input  logic              clk,
   input  logic              clr,
   output cpu_pkg::word_t    imem_addr,
   input  cpu_pkg::word_t    imem_data,
   output cpu_pkg::word_t    dmem_addr,
   output cpu_pkg::word_t    dmem_wdata,
   output logic              dmem_we,
   input  cpu_pkg::word_t    dmem_rdata,
   output logic              wb_en,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   // Fetch/decode
   word_t    fd_pc;
   word_t    fd_instr;
   logic     stall;

   // Register file read side
   reg_idx_t rd_addr_a;
   reg_idx_t rd_addr_b;
   word_t    rd_data_a;
   word_t    rd_data_b;

   // Decode/execute
   word_t    dx_pc;
   word_t    dx_instr;
   word_t    dx_a;
   word_t    dx_b;

   // Branch resolution and execute/memory
   logic     redirect;
   word_t    redirect_pc;
   word_t    xm_instr;
   word_t    xm_result;

   cpu_fetch #(
      .reset_pc (reset_pc)
   ) u_cpu_fetch (.*);

   cpu_decode u_cpu_decode (.*);

   cpu_regfile u_cpu_regfile (.*);

   cpu_execute u_cpu_execute (.*);

   cpu_writeback u_cpu_writeback (.*);

endmodule

// ==== hw/cpu_writeback.sv ====
/*
 Memory/writeback register and result select
 Load data arrives from the synchronous data memory during this stage
*/
`timescale 1ns/1ns

module cpu_writeback (
   input  logic              clk,
   input  logic              clr,
   input  cpu_pkg::word_t    xm_instr,
   input  cpu_pkg::word_t    xm_result,
   input  cpu_pkg::word_t    dmem_rdata,
   output logic              wb_en,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   word_t mw_instr;
   word_t mw_result;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         mw_instr <= nop_word;
      end else begin
         mw_instr <= xm_instr;
      end
   end

   always_ff @(posedge clk) begin
      mw_result <= xm_result;
   end

   assign wb_en   = writes_rd(mw_instr);   // ALU, addi, lw to a nonzero rd
   assign wb_reg  = rd_of(mw_instr);
   assign wb_data = (op_of(mw_instr) == op_lw) ? dmem_rdata : mw_result;

endmodule

// ==== list.f ====
+incdir+test
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_regfile.sv
hw/cpu_execute.sv
hw/cpu_writeback.sv
hw/cpu_top.sv
test/tb_cpu.sv

// ==== test/tb_model.svh ====
/*
 Program builder and instruction-level reference model for tb_cpu
 Included inside the tb_cpu module body, after the imem array is declared
 Addresses are word indices, data addresses must stay below 256
*/

int       seed = 32'h7fb1b84b;
int       prog_len;
word_t    end_pc;
reg_idx_t exp_wr_reg [$];
word_t    exp_wr_data [$];
word_t    exp_st_addr [$];
word_t    exp_st_data [$];

function automatic word_t enc_r(alu_fn_e fn, int rd, int rs, int rt, int sh);
   return {op_alu, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn, 2'b00};
endfunction

function automatic word_t enc_i(opcode_e op, int rd, int rs, int imm);
   return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic word_t enc_j(int target);
   return {op_j, target[26:0]};
endfunction

// Power-up data memory contents
function automatic word_t mem_fill(word_t addr);
   return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
endfunction

task automatic build_program();
   int    pos;
   int    neg;
   int    sh1;
   int    sh2;
   word_t p [$];
   pos = $random(seed) & 32'h3fff;
   neg = -(($random(seed) & 32'h7fff) + 1);
   sh1 = $random(seed) & 31;
   sh2 = $random(seed) & 31;
   p.push_back(enc_i(op_addi, 1, 0, pos));
   p.push_back(enc_i(op_addi, 2, 0, neg));
   p.push_back(enc_r(fn_add, 3, 1, 2, 0));    // Operands from both later stages
   p.push_back(enc_r(fn_sub, 4, 3, 1, 0));
   p.push_back(enc_r(fn_and, 5, 4, 3, 0));
   p.push_back(enc_r(fn_or, 6, 5, 4, 0));
   p.push_back(enc_r(fn_sll, 7, 6, 0, sh1));
   p.push_back(enc_r(fn_sra, 8, 7, 0, sh2));
   p.push_back(enc_i(op_addi, 0, 1, 5));      // r0 target, never retires
   p.push_back(enc_r(fn_add, 9, 0, 8, 0));
   p.push_back(enc_i(op_addi, 10, 0, 64));    // Data base address
   p.push_back(enc_i(op_sw, 9, 10, 3));
   p.push_back(enc_i(op_lw, 11, 10, 3));      // Reads back the store
   p.push_back(enc_r(fn_add, 12, 11, 1, 0));  // Load-use bubble
   p.push_back(enc_i(op_lw, 13, 10, 10));
   p.push_back(enc_r(fn_sub, 14, 13, 11, 0));
   p.push_back(enc_i(op_bne, 1, 1, 5));       // Not taken
   p.push_back(enc_i(op_addi, 15, 0, 1));
   p.push_back(enc_i(op_bne, 15, 0, 2));      // Taken, lands on 21
   p.push_back(enc_i(op_addi, 16, 0, 99));
   p.push_back(enc_i(op_addi, 17, 0, 77));
   p.push_back(enc_j(24));
   p.push_back(enc_i(op_addi, 18, 0, 55));
   p.push_back(enc_i(op_addi, 19, 0, 44));
   p.push_back(enc_i(op_sw, 14, 10, -2));
   p.push_back(enc_r(fn_add, 20, 14, 12, 0));
   p.push_back(enc_j(26));                    // Self-jump
   for (int i = 0; i < 64; i++) begin
      imem[i] = (i < p.size()) ? p[i] : nop_word;
   end
   prog_len = p.size();
   end_pc   = word_t'(prog_len - 1);
endtask

// Runs the program one instruction at a time until the self-jump
function automatic void run_reference();
   word_t      r [32];
   word_t      stored [word_t];
   word_t      pc;
   word_t      ins;
   word_t      a;
   word_t      res;
   word_t      imm;
   word_t      tgt;
   logic [4:0] op;
   logic [4:0] rd;
   logic [4:0] rs;
   logic [4:0] rt;
   logic [4:0] sh;
   logic [4:0] fn;
   logic       wr;
   logic       done;
   for (int i = 0; i < 32; i++) begin
      r[i] = '0;
   end
   pc   = '0;
   res  = '0;
   done = 1'b0;
   for (int step = 0; step < 500 && !done; step++) begin
      ins = imem[pc[5:0]];
      op  = ins[31:27];
      rd  = ins[26:22];
      rs  = ins[21:17];
      rt  = ins[16:12];
      sh  = ins[11:7];
      fn  = ins[6:2];
      imm = {{15{ins[16]}}, ins[16:0]};
      a   = r[rs];
      wr  = 1'b0;
      pc  = pc + 1;
      case (op)
         op_alu: begin
            wr = 1'b1;
            case (fn)
               fn_add:  res = a + r[rt];
               fn_sub:  res = a - r[rt];
               fn_and:  res = a & r[rt];
               fn_or:   res = a | r[rt];
               fn_sll:  res = a << sh;
               fn_sra:  res = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : '0);
               default: res = '0;
            endcase
         end
         op_addi: begin
            wr  = 1'b1;
            res = a + imm;
         end
         op_lw: begin
            wr  = 1'b1;
            res = stored.exists(a + imm) ? stored[a + imm] : mem_fill(a + imm);
         end
         op_sw: begin
            stored[a + imm] = r[rd];
            exp_st_addr.push_back(a + imm);
            exp_st_data.push_back(r[rd]);
         end
         op_bne: begin
            if (r[rd] != a) begin
               pc = pc + imm;                 // pc already points past the branch
            end
         end
         op_j: begin
            tgt  = {{5{ins[26]}}, ins[26:0]};
            done = (tgt == pc - 1);
            pc   = tgt;
         end
         default: done = 1'b1;
      endcase
      if (wr && rd != 5'd0) begin
         r[rd] = res;
         exp_wr_reg.push_back(rd);
         exp_wr_data.push_back(res);
      end
   end
endfunction

// ==== test/tb_cpu.sv ====
/*
 Testbench for cpu_top with behavioral instruction and data memories
 Instruction memory holds 64 words and reads combinationally
 Data memory holds 256 words indexed by the low address bits, synchronous read
 A watchdog bounds the run length
*/
`timescale 1ns/1ns

module tb_cpu;
   import cpu_pkg::*;

   logic     clk = 1'b0;
   logic     clr = 1'b1;
   word_t    imem_addr;
   word_t    imem_data;
   word_t    dmem_addr;
   word_t    dmem_wdata;
   logic     dmem_we;
   word_t    dmem_rdata = '0;
   logic     wb_en;
   reg_idx_t wb_reg;
   word_t    wb_data;

   word_t    imem [64];
   word_t    dmem [256];
   logic     built = 1'b0;
   int       wr_seen = 0;
   int       st_seen = 0;
   int       visits;

   `include "tb_model.svh"

   cpu_top #(
      .reset_pc (32'd0)
   ) u_cpu_top (.*);

   initial begin
      forever #10 clk = ~clk;
   end

   assign imem_data = (imem_addr < 64) ? imem[imem_addr[5:0]] : nop_word;

   always @(posedge clk) begin
      if (clr) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= mem_fill(word_t'(i));
         end
         dmem_rdata <= '0;
      end else begin
         if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
         end
         dmem_rdata <= dmem[dmem_addr[7:0]];   // Previous-cycle address
      end
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(word_t got, word_t exp, string what);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
                             $time, what, got, exp));
      end
   endtask

   // Retirements and stores in program order
   always @(negedge clk) begin
      if (!clr && wb_en) begin
         if (wr_seen >= exp_wr_reg.size()) begin
            abort_run("Register write seen after the last expected one");
         end else begin
            check_value(word_t'(wb_reg), word_t'(exp_wr_reg[wr_seen]), "write register");
            check_value(wb_data, exp_wr_data[wr_seen], "write data");
            wr_seen++;
         end
      end
      if (!clr && dmem_we) begin
         if (st_seen >= exp_st_addr.size()) begin
            abort_run("Store seen after the last expected one");
         end else begin
            check_value(dmem_addr, exp_st_addr[st_seen], "store address");
            check_value(dmem_wdata, exp_st_data[st_seen], "store data");
            st_seen++;
         end
      end
   end

   initial begin
      build_program();
      run_reference();
      built = 1'b1;
      repeat (8) begin
         @(negedge clk);
         check_value(word_t'(wb_en), '0, "wb_en during reset");
         check_value(word_t'(dmem_we), '0, "dmem_we during reset");
      end
      clr = 1'b0;
      while (!wb_en) begin
         check_value(word_t'(dmem_we), '0, "dmem_we before first retirement");
         @(negedge clk);
      end
      while (wr_seen < exp_wr_reg.size() || st_seen < exp_st_addr.size()) begin
         @(negedge clk);
      end
      // Self-jump refetches the last word every third cycle
      visits = 0;
      repeat (15) begin
         @(negedge clk);
         if (imem_addr == end_pc) begin
            visits++;
         end
      end
      if (visits >= 3) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         abort_run("The program did not settle in its closing self-jump");
      end
   end

   initial begin
      wait (built);
      repeat (8 + prog_len * 4 + 50) begin
         @(posedge clk);
      end
      abort_run("Timeout: the program did not finish within its cycle budget");
   end

endmodule
